//--- source/buf_geom_pkg.sv
package buf_geom_pkg;

   //------------------------------------------------------------
   // Ring geometry
   //------------------------------------------------------------
   localparam int BUF_WORDS  = 16;                    // Ring depth in words
   localparam int WORD_ADR_W = $clog2(BUF_WORDS);     // Word index width

   // Byte lanes per stored word
   localparam int LANES      = 4;
   localparam int LANE_W     = $clog2(LANES);         // Lane select width

   // Byte address is word index on top, lane below
   localparam int BYTE_ADR_W = WORD_ADR_W + LANE_W;

   // Counters must reach BUF_WORDS itself, hence one extra bit
   localparam int CNT_W      = WORD_ADR_W + 1;

endpackage

//--- source/wb_bus_pkg.sv
package wb_bus_pkg;

   //------------------------------------------------------------
   // Bus data widths
   //------------------------------------------------------------
   localparam int WORD_W = 32;   // Word port on the producer side
   localparam int BYTE_W = 8;    // Byte port on the consumer side

   // One stored word seen two ways
   // The producer loads it whole and the memory splits it per lane
   // Lane 0 sits in the low byte
   typedef union packed {
      logic [WORD_W-1:0]                          word;   // Whole word
      logic [buf_geom_pkg::LANES-1:0][BYTE_W-1:0] lanes;  // Per-lane bytes
   } lane_word_u;

endpackage

//--- source/wb_if.sv
`timescale 1ns/1ps

// Wishbone classic, single transfers only
interface wb_if #(
   parameter int DAT_W = wb_bus_pkg::WORD_W,
   parameter int ADR_W = buf_geom_pkg::WORD_ADR_W
);

   logic             cyc;    // Bus cycle in progress
   logic             stb;    // Transfer strobe
   logic             we;     // Write enable
   logic             ack;    // Slave acknowledge, one cycle
   logic [ADR_W-1:0] adr;    // Address, held until ack
   logic [DAT_W-1:0] dat_w;  // Master to slave data
   logic [DAT_W-1:0] dat_r;  // Slave to master data, valid with ack

   // Initiator side
   modport master (
      output cyc, stb, we, adr, dat_w,
      input  ack, dat_r
   );

   // Target side
   modport slave (
      input  cyc, stb, we, adr, dat_w,
      output ack, dat_r
   );

endinterface

//--- source/word_writer.sv
`timescale 1ns/1ps

module word_writer (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          word_valid_i,
   input  logic [wb_bus_pkg::WORD_W-1:0] word_data_i,
   output logic                          word_ready_o,
   input  logic                          word_released_i,
   output logic                          word_committed_o,
   wb_if.master                          wb
);

   logic                                bus_q;        // Write cycle on the bus
   logic                                hold_q;       // Waiting for a free slot
   logic [buf_geom_pkg::WORD_ADR_W-1:0] wr_ptr;       // Next ring slot
   logic [buf_geom_pkg::CNT_W-1:0]      credit;       // Free slots left
   logic [buf_geom_pkg::CNT_W-1:0]      credit_next;
   wb_bus_pkg::lane_word_u              word_q;       // Captured input word
   logic                                accept;
   logic                                commit;

   // Idle is neither flag set
   assign word_ready_o     = !bus_q && !hold_q && (credit != '0);
   assign accept           = word_valid_i && word_ready_o;
   assign commit           = bus_q && wb.ack;        // Write landed this cycle
   assign word_committed_o = commit;

   //------------------------------------------------------------
   // Credit, down on commit and up on release
   //------------------------------------------------------------
   always_comb begin
      case ({commit, word_released_i})
         2'b10:   credit_next = credit - buf_geom_pkg::CNT_W'(1);
         2'b01:   credit_next = credit + buf_geom_pkg::CNT_W'(1);
         default: credit_next = credit;               // Both or neither
      endcase
   end

   //------------------------------------------------------------
   // Control: idle, bus, done
   //------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bus_q  <= 1'b0;
         hold_q <= 1'b1;                              // Ready comes up after reset
         credit <= buf_geom_pkg::CNT_W'(buf_geom_pkg::BUF_WORDS);
         wr_ptr <= '0;
      end else begin
         credit <= credit_next;
         if (accept) begin
            bus_q <= 1'b1;                            // Cycle starts next edge
         end else if (commit) begin
            bus_q  <= 1'b0;                           // Drop cyc and stb after ack
            hold_q <= (credit_next == '0);            // Ring now full
            wr_ptr <= wr_ptr + 1'b1;                  // Wraps at BUF_WORDS
         end else if (hold_q) begin
            hold_q <= (credit_next == '0);
         end
      end
   end

   // Payload, no reset needed
   always_ff @(posedge clk_i) begin
      if (accept) begin
         word_q.word <= word_data_i;
      end
   end

   // Bus drive, held steady for the whole cycle
   assign wb.cyc   = bus_q;
   assign wb.stb   = bus_q;
   assign wb.we    = bus_q;                           // Writes only
   assign wb.adr   = wr_ptr;
   assign wb.dat_w = word_q.word;

endmodule

//--- source/byte_lane_sram.sv
`timescale 1ns/1ps

module byte_lane_sram (
   input  logic clk_i,
   input  logic rst_i,
   wb_if.slave  word_port,   // 32-bit write side
   wb_if.slave  byte_port    // 8-bit read side
);

   //------------------------------------------------------------
   // Storage
   //------------------------------------------------------------
   // One byte-wide bank per lane, same word index in all four
   logic [wb_bus_pkg::BYTE_W-1:0] bank_mem [buf_geom_pkg::LANES][buf_geom_pkg::BUF_WORDS];

   //------------------------------------------------------------
   // Word port
   //------------------------------------------------------------
   logic                   word_ack_q;
   logic                   word_start;  // First cycle of cyc and stb
   wb_bus_pkg::lane_word_u wr_word;     // Incoming word, split by lane

   assign word_start = word_port.cyc && word_port.stb && !word_ack_q;
   assign wr_word    = word_port.dat_w;

   // Ack one edge after stb, never twice in a row
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         word_ack_q <= 1'b0;
      end else begin
         word_ack_q <= word_start;
      end
   end

   // Write lands on the edge that raises ack
   always_ff @(posedge clk_i) begin
      if (word_start && word_port.we) begin
         for (int l = 0; l < buf_geom_pkg::LANES; l++) begin
            bank_mem[l][word_port.adr] <= wr_word.lanes[l];  // Lane l to bank l
         end
      end
   end

   assign word_port.ack   = word_ack_q;
   assign word_port.dat_r = '0;           // Write-only port, reads return zero

   //------------------------------------------------------------
   // Byte port
   //------------------------------------------------------------
   logic                                byte_ack_q;
   logic                                byte_start;
   logic [buf_geom_pkg::WORD_ADR_W-1:0] rd_idx;      // Word index part
   logic [buf_geom_pkg::LANE_W-1:0]     rd_lane;     // Bank select part
   logic [wb_bus_pkg::BYTE_W-1:0]       rd_data_q;   // Registered read byte

   assign byte_start        = byte_port.cyc && byte_port.stb && !byte_ack_q;
   assign {rd_idx, rd_lane} = byte_port.adr;

   // Same single-transfer ack rule as the word port
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         byte_ack_q <= 1'b0;
      end else begin
         byte_ack_q <= byte_start;
      end
   end

   // Lane picks the bank, index picks the byte
   always_ff @(posedge clk_i) begin
      if (byte_start && !byte_port.we) begin
         rd_data_q <= bank_mem[rd_lane][rd_idx];
      end
   end

   // Data valid while ack is high
   assign byte_port.ack   = byte_ack_q;
   assign byte_port.dat_r = rd_data_q;

endmodule

//--- source/byte_reader.sv
`timescale 1ns/1ps

module byte_reader (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          word_committed_i,
   output logic                          word_released_o,
   output logic                          byte_valid_o,
   output logic [wb_bus_pkg::BYTE_W-1:0] byte_data_o,
   input  logic                          byte_ready_i,
   wb_if.master                          wb
);

   logic                                busy_q;       // Read cycle on the bus
   logic                                out_valid_q;  // Holding register full
   logic [wb_bus_pkg::BYTE_W-1:0]       out_data_q;   // Holding register
   logic [buf_geom_pkg::CNT_W-1:0]      stored;       // Words not yet released
   logic [buf_geom_pkg::WORD_ADR_W-1:0] rd_word;      // Word pointer
   logic [buf_geom_pkg::LANE_W-1:0]     rd_lane;      // Lane within the word
   logic                                out_free;
   logic                                issue;
   logic                                land;
   logic                                word_done;

   // Empty now, or the byte leaves on this edge
   assign out_free  = !out_valid_q || byte_ready_i;
   assign issue     = !busy_q && (stored != '0) && out_free;
   assign land      = busy_q && wb.ack;               // Read byte on dat_r
   assign word_done = land && (rd_lane == buf_geom_pkg::LANE_W'(buf_geom_pkg::LANES - 1));

   assign word_released_o = word_done;

   //------------------------------------------------------------
   // Stored-word count
   //------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         stored <= '0;
      end else begin
         case ({word_committed_i, word_done})
            2'b10:   stored <= stored + buf_geom_pkg::CNT_W'(1);
            2'b01:   stored <= stored - buf_geom_pkg::CNT_W'(1);
            default: stored <= stored;                // Both cancel out
         endcase
      end
   end

   //------------------------------------------------------------
   // Bus cycle and address stepping
   //------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_q  <= 1'b0;
         rd_word <= '0;
         rd_lane <= '0;
      end else begin
         if (issue) begin
            busy_q <= 1'b1;
         end else if (land) begin
            busy_q <= 1'b0;                           // Drop cyc after ack
         end
         if (land) begin
            rd_lane <= rd_lane + 1'b1;                // Lane 3 wraps to 0
            if (word_done) begin
               rd_word <= rd_word + 1'b1;             // Next ring slot
            end
         end
      end
   end

   //------------------------------------------------------------
   // Output holding register
   //------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         out_valid_q <= 1'b0;
      end else if (land) begin
         out_valid_q <= 1'b1;                         // Valid rises after ack
      end else if (out_valid_q && byte_ready_i) begin
         out_valid_q <= 1'b0;                         // Transfer done
      end
   end

   // Payload, no reset
   always_ff @(posedge clk_i) begin
      if (land) begin
         out_data_q <= wb.dat_r;
      end
   end

   assign byte_valid_o = out_valid_q;
   assign byte_data_o  = out_data_q;

   // Bus drive, reads only
   assign wb.cyc   = busy_q;
   assign wb.stb   = busy_q;
   assign wb.we    = 1'b0;
   assign wb.adr   = {rd_word, rd_lane};
   assign wb.dat_w = '0;

endmodule

//--- source/byte_stream_buffer.sv
`timescale 1ns/1ps

module byte_stream_buffer (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          word_valid_i,
   input  logic [wb_bus_pkg::WORD_W-1:0] word_data_i,
   output logic                          word_ready_o,
   output logic                          byte_valid_o,
   output logic [wb_bus_pkg::BYTE_W-1:0] byte_data_o,
   input  logic                          byte_ready_i
);

   //------------------------------------------------------------
   // Internal buses
   //------------------------------------------------------------
   wb_if #(.DAT_W(wb_bus_pkg::WORD_W), .ADR_W(buf_geom_pkg::WORD_ADR_W)) word_bus ();
   wb_if #(.DAT_W(wb_bus_pkg::BYTE_W), .ADR_W(buf_geom_pkg::BYTE_ADR_W)) byte_bus ();

   logic word_committed;   // Writer to reader, one word stored
   logic word_released;    // Reader to writer, one slot free

   // Producer side
   word_writer word_writer_inst (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .word_valid_i     (word_valid_i),
      .word_data_i      (word_data_i),
      .word_ready_o     (word_ready_o),
      .word_released_i  (word_released),
      .word_committed_o (word_committed),
      .wb               (word_bus)
   );

   // Ring storage
   byte_lane_sram byte_lane_sram_inst (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .word_port (word_bus),
      .byte_port (byte_bus)
   );

   // Consumer side
   byte_reader byte_reader_inst (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .word_committed_i (word_committed),
      .word_released_o  (word_released),
      .byte_valid_o     (byte_valid_o),
      .byte_data_o      (byte_data_o),
      .byte_ready_i     (byte_ready_i),
      .wb               (byte_bus)
   );

endmodule

//--- sim/byte_stream_buffer_assertions.sv
`timescale 1ns/1ps

module byte_stream_buffer_assertions (
   input logic                          clk_i,
   input logic                          rst_i,
   input logic                          word_cyc_i,
   input logic                          word_stb_i,
   input logic                          word_ack_i,
   input logic                          byte_cyc_i,
   input logic                          byte_stb_i,
   input logic                          byte_ack_i,
   input logic                          byte_valid_i,
   input logic                          byte_ready_i,
   input logic [wb_bus_pkg::BYTE_W-1:0] byte_data_i
);

   int unsigned fail_cnt = 0;   // Assertion failures so far

   //------------------------------------------------------------
   // Wishbone single-transfer rule
   //------------------------------------------------------------
   word_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
      word_ack_i |=> !word_ack_i)
   else begin
      $error("word bus ack high two cycles in a row");
      fail_cnt++;
   end

   byte_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
      byte_ack_i |=> !byte_ack_i)
   else begin
      $error("byte bus ack high two cycles in a row");
      fail_cnt++;
   end

   // Ack only inside a strobed cycle
   word_ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      word_ack_i |-> (word_cyc_i && word_stb_i))
   else begin
      $error("word bus ack without cyc/stb");
      fail_cnt++;
   end

   byte_ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      byte_ack_i |-> (byte_cyc_i && byte_stb_i))
   else begin
      $error("byte bus ack without cyc/stb");
      fail_cnt++;
   end

   // Output stream holds until taken
   byte_valid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (byte_valid_i && !byte_ready_i) |=> (byte_valid_i && $stable(byte_data_i)))
   else begin
      $error("byte output changed before transfer");
      fail_cnt++;
   end

endmodule

//--- sim/byte_stream_buffer_tb.sv
`timescale 1ns/1ps

module byte_stream_buffer_tb;

   logic        clk_i;
   logic        rst_i;
   logic        word_valid_i;
   logic [31:0] word_data_i;
   logic        word_ready_o;
   logic        byte_valid_o;
   logic [7:0]  byte_data_o;
   logic        byte_ready_i;

   // Test table from the vector file
   string       names[$];
   int          modes[$];
   int          counts[$];
   logic [31:0] words[$];
   logic [7:0]  exp_q[$];                            // Scoreboard with lane 0 first

   string       cur_name;
   int          cur_mode;
   int          cur_count;                            // Words in the running test
   int          received;
   int          accepted;
   int          low_cnt;                              // Cycles word_ready_o held low
   bit          drv_done;
   bit          release_q;                            // Mode 2 stall lifted
   int          wd_limit;
   logic [31:0] lfsr = 32'h7672_c564;

   byte_stream_buffer byte_stream_buffer_inst (.*);

   bind byte_stream_buffer byte_stream_buffer_assertions byte_stream_buffer_assertions_inst (
      .clk_i(clk_i), .rst_i(rst_i),
      .word_cyc_i(word_bus.cyc), .word_stb_i(word_bus.stb), .word_ack_i(word_bus.ack),
      .byte_cyc_i(byte_bus.cyc), .byte_stb_i(byte_bus.stb), .byte_ack_i(byte_bus.ack),
      .byte_valid_i(byte_valid_o), .byte_ready_i(byte_ready_i), .byte_data_i(byte_data_o)
   );

   always #50 clk_i = ~clk_i;                        // 100 ns period

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      if (exp !== act) begin
         $display("ERROR test %s expected %h actual %h", name, exp, act);
         $display(">>> FAIL");
         $fatal(1);
      end
   endtask

   task automatic fail_with(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   //------------------------------------------------------------
   // Output ready stepped on each falling edge
   //------------------------------------------------------------
   always @(negedge clk_i) begin
      if (!rst_i) begin
         if (word_valid_i && !word_ready_o)
            low_cnt = low_cnt + 1;
         else
            low_cnt = 0;
         if (cur_mode == 2 && !release_q && (drv_done || low_cnt >= 20)) begin
            release_q = 1'b1;
            // Ring holds 16 words so a longer test stalls at 16
            compare_value({cur_name, "_accepted"}, (cur_count > 16) ? 16 : cur_count,
                          accepted);
         end
         case (cur_mode)
            1: begin
               lfsr = lfsr_step(lfsr);
               byte_ready_i = lfsr[0];
            end
            2:       byte_ready_i = release_q;
            default: byte_ready_i = 1'b1;
         endcase
      end
   end

   // Output monitor against the scoreboard
   always @(posedge clk_i) begin
      if (!rst_i && byte_valid_o && byte_ready_i) begin
         if (exp_q.size() == 0) begin
            fail_with("Output produced a byte that was never written");
         end else begin
            compare_value(cur_name, exp_q.pop_front(), byte_data_o);
            received = received + 1;
         end
      end
   end

   task automatic send_word(input logic [31:0] w);
      bit got;
      got = 1'b0;
      @(negedge clk_i);
      word_valid_i = 1'b1;
      word_data_i  = w;
      while (!got) begin
         @(posedge clk_i);
         got = word_ready_o;
      end
      for (int l = 0; l < 4; l++)
         exp_q.push_back(w[8*l +: 8]);                // Least significant lane first
      accepted = accepted + 1;
      @(negedge clk_i);
      word_valid_i = 1'b0;
   endtask

   //------------------------------------------------------------
   // Watchdog over 40 cycles per word plus margin
   //------------------------------------------------------------
   initial begin
      wait (wd_limit > 0);
      repeat (wd_limit) @(posedge clk_i);
      fail_with("Timeout: the output stream stalled before all bytes arrived");
   end

   // Any bound assertion failure ends the run
   initial begin
      wait (byte_stream_buffer_inst.byte_stream_buffer_assertions_inst.fail_cnt != 0);
      fail_with("A bus or output stream protocol assertion failed");
   end

   initial begin
      int          fd;
      int          n;
      int          m;
      int          c;
      int          base;
      logic [31:0] w;
      string       tok;
      string       line;
      clk_i        = 1'b0;
      rst_i        = 1'b1;
      word_valid_i = 1'b0;
      word_data_i  = '0;
      byte_ready_i = 1'b0;
      cur_mode     = 0;
      cur_count    = 0;
      cur_name     = "reset";
      received     = 0;
      accepted     = 0;
      low_cnt      = 0;
      drv_done     = 1'b0;
      release_q    = 1'b0;
      wd_limit     = 0;
      fd = $fopen("sim/stream_tests.txt", "r");
      if (fd == 0)
         fail_with("Could not open sim/stream_tests.txt");
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok[0] == "#") begin
            n = $fgets(line, fd);                     // Skip rest of comment
         end else begin
            n = $fscanf(fd, "%d %d", m, c);
            names.push_back(tok);
            modes.push_back(m);
            counts.push_back(c);
            for (int i = 0; i < c; i++) begin
               n = $fscanf(fd, "%h", w);
               words.push_back(w);
            end
         end
      end
      $fclose(fd);
      wd_limit = 40 * words.size() + 200;

      repeat (10) @(posedge clk_i);
      compare_value("reset_word_ready", 0, word_ready_o);
      compare_value("reset_byte_valid", 0, byte_valid_o);
      @(negedge clk_i);
      rst_i = 1'b0;
      n = 0;
      while (!word_ready_o && n < 5) begin            // Ready within a few cycles
         @(negedge clk_i);
         n = n + 1;
      end
      if (!word_ready_o)
         fail_with("word_ready_o did not rise after reset");

      base = 0;
      foreach (names[t]) begin
         @(negedge clk_i);
         cur_name  = names[t];
         cur_mode  = modes[t];
         cur_count = counts[t];
         received  = 0;
         accepted  = 0;
         drv_done  = 1'b0;
         release_q = 1'b0;
         for (int i = 0; i < counts[t]; i++)
            send_word(words[base + i]);
         drv_done = 1'b1;
         while (received < 4 * counts[t])
            @(negedge clk_i);
         // A stray read would raise valid within three edges
         repeat (4) begin
            @(negedge clk_i);
            compare_value({cur_name, "_idle_valid"}, 0, byte_valid_o);
         end
         base = base + counts[t];
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

//--- vlog.f
source/buf_geom_pkg.sv
source/wb_bus_pkg.sv
source/wb_if.sv
source/word_writer.sv
source/byte_lane_sram.sv
source/byte_reader.sv
source/byte_stream_buffer.sv
sim/byte_stream_buffer_assertions.sv
sim/byte_stream_buffer_tb.sv

//--- sim/stream_tests.txt
# columns: test name, stall mode, word count, then that many hex words
# stall mode 0 ready always, 1 random ready, 2 ready held until ring full
basic 0 4
   03020100 07060504 0b0a0908 deadbeef

random_stall 1 12
   11223344 55667788 99aabbcc ddeeff00 01234567 89abcdef
   fedcba98 76543210 a5a5a5a5 5a5a5a5a 0f0f0f0f f0f0f0f0

full_ring 2 20
   10000001 20000002 30000003 40000004 50000005
   60000006 70000007 80000008 90000009 a000000a
   b000000b c000000c d000000d e000000e f000000f
   00000010 c0ffee11 c0ffee12 c0ffee13 c0ffee14

ring_wrap 0 24
   00010203 04050607 08090a0b 0c0d0e0f 10111213 14151617
   18191a1b 1c1d1e1f 20212223 24252627 28292a2b 2c2d2e2f
   30313233 34353637 38393a3b 3c3d3e3f 40414243 44454647
   48494a4b 4c4d4e4f 50515253 54555657 58595a5b 5c5d5e5f
